/* ddc.f */
common/ddcPkg.sv
common/regPkg.sv
common/cpuBus.sv
logic/ddcRegs.sv
logic/nco.sv
logic/complexMixer.sv
logic/halfbandDecimate.sv
cic/cicDecimator.sv
logic/variableGain.sv
logic/ddc.sv
test/ddcTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module ddcTb -f ddc.f
output=$(./obj_dir/VddcTb)
echo "$output"
echo "$output" | grep -qx "test passed"

/* test/ddcTb.sv */
`timescale 1ns/1ps

module ddcTb;

    logic            clk;
    logic            reset;
    logic            syncIn;
    ddcPkg::sampleT  iIn;
    ddcPkg::sampleT  qIn;
    logic            wr0, wr1, wr2, wr3;
    regPkg::busAddrT addr;
    regPkg::busDataT din;
    regPkg::busDataT dout;
    ddcPkg::freqT    freqOffset;
    logic            offsetEn;
    logic [20:0]     agcGain;
    logic            syncOut;
    ddcPkg::sampleT  iOut;
    ddcPkg::sampleT  qOut;

    int checkCount = 0;
    int mismatchCount = 0;
    int testCount = 0;
    int testsWithErrors = 0;
    int errorsAtStart = 0;

    localparam regPkg::busAddrT centerAddr  = {regPkg::ddcSpaceBase, regPkg::centerFreqAddr};
    localparam regPkg::busAddrT ctrlRegAddr = {regPkg::ddcSpaceBase, regPkg::controlAddr};
    localparam regPkg::busAddrT rateAddr    = {regPkg::cicSpaceBase, regPkg::cicRateAddr};

    ddc ddc_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnTimeout(string what);
        $display("Timeout while waiting for %s", what);
        $display("test failed");
        $finish;
    endtask

    task automatic startTest();
        errorsAtStart = mismatchCount;
        testCount++;
    endtask

    task automatic finishTest(string name);
        if (mismatchCount == errorsAtStart) begin
            $display("%s: PASS", name);
        end else begin
            testsWithErrors++;
            $display("%s: FAIL, %0d mismatches", name, mismatchCount - errorsAtStart);
        end
    endtask

    task automatic compareBus(string name, regPkg::busDataT expected, regPkg::busDataT actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Two LSB of slack for rounding along the chain
    task automatic compareSample(string name, ddcPkg::sampleT expected, ddcPkg::sampleT actual);
        int diff;
        diff = int'(actual) - int'(expected);
        checkCount++;
        if ($isunknown(actual) || diff > 2 || diff < -2) begin
            mismatchCount++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic compareMagnitude(string name, longint expected, longint actual);
        longint diff;
        diff = (actual > expected) ? actual - expected : expected - actual;
        checkCount++;
        if (diff * 100 > expected) begin
            mismatchCount++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic regPkg::busDataT mergeBytes(regPkg::busDataT old,
                                                   regPkg::busDataT data, logic [3:0] strobe);
        regPkg::busDataT mask;
        mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic regPkg::busDataT controlWord(logic bypassCic, logic bypassHb);
        regPkg::busDataT word;
        word = '0;
        word[regPkg::bypassCicBit] = bypassCic;
        word[regPkg::bypassHbBit]  = bypassHb;
        return word;
    endfunction

    // Product with the LO, half-LSB rounding, then 17 bits dropped
    function automatic ddcPkg::sampleT mixRule(ddcPkg::sampleT a, ddcPkg::sampleT lo);
        longint p;
        p = longint'(a) * longint'(lo) + 64'sd65536;
        return ddcPkg::sampleT'(p >>> 17);
    endfunction

    function automatic ddcPkg::sampleT gainRule(ddcPkg::cicAccT word, ddcPkg::gainExpT e,
                                                ddcPkg::gainManT m);
        ddcPkg::wideT v;
        v = ddcPkg::wideT'(word) <<< e;
        v = v * ddcPkg::wideT'({1'b0, m});
        v = v >>> (15 + 30);
        if (v > 128'sd131071) begin
            return 18'sd131071;
        end
        if (v < -128'sd131072) begin
            return -18'sd131072;
        end
        return ddcPkg::sampleT'(v);
    endfunction

    function automatic longint sqMag(ddcPkg::sampleT i, ddcPkg::sampleT q);
        return longint'(i) * longint'(i) + longint'(q) * longint'(q);
    endfunction

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic busWrite(regPkg::busAddrT a, regPkg::busDataT data, logic [3:0] strobe);
        @(posedge clk);
        addr <= a;
        din  <= data;
        {wr3, wr2, wr1, wr0} <= strobe;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic busRead(regPkg::busAddrT a, output regPkg::busDataT data);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        data = dout;
    endtask

    task automatic latchOffset(ddcPkg::freqT value);
        @(posedge clk);
        freqOffset <= value;
        offsetEn   <= 1'b1;
        @(posedge clk);
        offsetEn   <= 1'b0;
    endtask

    task automatic setGain(ddcPkg::gainExpT e, ddcPkg::gainManT m);
        @(posedge clk);
        agcGain <= {e, m};
    endtask

    // Syncs on every cycle until enough outputs, keeps the last one
    task automatic streamUntil(int outputs, output ddcPkg::sampleT gotI,
                               output ddcPkg::sampleT gotQ);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < outputs && cycles < 1000) begin
            @(posedge clk);
            syncIn <= 1'b1;
            @(negedge clk);
            cycles++;
            if (syncOut) begin
                seen++;
                gotI = iOut;
                gotQ = qOut;
            end
        end
        @(posedge clk);
        syncIn <= 1'b0;
        if (seen < outputs) begin
            stopOnTimeout("output syncs of the DC stream");
        end
    endtask

    task automatic resetStateTest();
        regPkg::busDataT rate;
        int highCycles;
        startTest();
        highCycles = 0;
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            if (syncOut !== 1'b0) begin
                highCycles++;
            end
        end
        checkCount++;
        if (highCycles != 0) begin
            mismatchCount++;
            $display("resetState: syncOut was high on %0d cycles with no input sync",
                     highCycles);
        end
        busRead(rateAddr, rate);
        compareBus("resetState cicRate", 32'd4, rate);
        finishTest("resetState");
    endtask

    task automatic registerTest();
        regPkg::busAddrT addrs [3];
        regPkg::busDataT model [3];
        regPkg::busDataT data;
        regPkg::busDataT got;
        logic [3:0]      strobe;
        startTest();
        addrs = '{centerAddr, ctrlRegAddr, rateAddr};
        model = '{32'd0, 32'd0, 32'd4};
        for (int n = 0; n < 8; n++) begin
            for (int r = 0; r < 3; r++) begin
                data   = $urandom();
                strobe = 4'($urandom());
                busWrite(addrs[r], data, strobe);
                model[r] = mergeBytes(model[r], data, strobe);
                busRead(addrs[r], got);
                compareBus($sformatf("registers 0x%03h", addrs[r]), model[r], got);
            end
        end
        finishTest("registers");
    endtask

    task automatic dcBypassTest();
        ddcPkg::sampleT gotI;
        ddcPkg::sampleT gotQ;
        ddcPkg::sampleT mixed;
        startTest();
        busWrite(centerAddr, 32'd0, 4'hF);
        latchOffset(32'd0);
        busWrite(ctrlRegAddr, controlWord(1'b1, 1'b1), 4'hF);
        // Unity gain with the 30 pad bits of the bypass word
        setGain(5'd0, 16'd32768);
        iIn <= 18'sd70000;
        qIn <= 18'sd0;
        streamUntil(30, gotI, gotQ);
        mixed = mixRule(18'sd70000, ddcPkg::sampleMax);
        compareSample("dcBypass iOut", gainRule({mixed, 30'd0}, 5'd0, 16'd32768), gotI);
        compareSample("dcBypass qOut", 18'sd0, gotQ);
        finishTest("dcBypass");
    endtask

    task automatic cicDecimateTest();
        ddcPkg::sampleT gotI;
        ddcPkg::sampleT gotQ;
        ddcPkg::sampleT hbLevel;
        int pulses;
        int quiet;
        int cycles;
        startTest();
        busWrite(ctrlRegAddr, controlWord(1'b0, 1'b0), 4'hF);
        busWrite(rateAddr, 32'd4, 4'hF);
        setGain(5'd25, 16'd24576);
        pulses = 0;
        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            syncIn <= 1'b1;
            iIn    <= 18'sd40000;
            qIn    <= 18'sd0;
            @(negedge clk);
            if (syncOut) begin
                pulses++;
                gotI = iOut;
                gotQ = qOut;
            end
        end
        @(posedge clk);
        syncIn <= 1'b0;
        quiet = 0;
        cycles = 0;
        while (quiet < 20 && cycles < 200) begin
            @(negedge clk);
            cycles++;
            quiet++;
            if (syncOut) begin
                pulses++;
                quiet = 0;
                gotI = iOut;
                gotQ = qOut;
            end
        end
        if (quiet < 20) begin
            stopOnTimeout("the decimated stream to drain");
        end
        checkCount++;
        if (pulses < 49 || pulses > 51) begin
            mismatchCount++;
            $display("FAILED cicDecimate pulses: expected 50 +/- 1, actual %0d", pulses);
        end
        // Halfband passes DC unchanged, CIC adds R cubed
        hbLevel = mixRule(18'sd40000, ddcPkg::sampleMax);
        compareSample("cicDecimate iOut",
                      gainRule(ddcPkg::cicAccT'(longint'(hbLevel) * 64), 5'd25, 16'd24576),
                      gotI);
        compareSample("cicDecimate qOut", 18'sd0, gotQ);
        finishTest("cicDecimate");
    endtask

    task automatic rotationTest();
        int seen;
        int cycles;
        startTest();
        busWrite(ctrlRegAddr, controlWord(1'b1, 1'b1), 4'hF);
        busWrite(centerAddr, 32'h0800_0000, 4'hF);
        latchOffset(32'h0800_0000);
        setGain(5'd0, 16'd32768);
        seen = 0;
        cycles = 0;
        while (seen < 48 && cycles < 1000) begin
            @(posedge clk);
            syncIn <= 1'b1;
            iIn    <= 18'sd50000;
            qIn    <= -18'sd30000;
            @(negedge clk);
            cycles++;
            if (syncOut) begin
                seen++;
                if (seen > 16) begin
                    compareMagnitude("rotation magnitude",
                                     sqMag(18'sd50000, -18'sd30000), sqMag(iOut, qOut));
                end
            end
        end
        @(posedge clk);
        syncIn <= 1'b0;
        if (seen < 48) begin
            stopOnTimeout("output syncs of the rotating LO");
        end
        finishTest("rotation");
    endtask

    initial begin
        void'($urandom(22085));
        reset      = 1'b1;
        syncIn     = 1'b0;
        iIn        = '0;
        qIn        = '0;
        wr0        = 1'b0;
        wr1        = 1'b0;
        wr2        = 1'b0;
        wr3        = 1'b0;
        addr       = '0;
        din        = '0;
        freqOffset = '0;
        offsetEn   = 1'b0;
        agcGain    = '0;
        applyReset();
        resetStateTest();
        registerTest();
        // Clears the NCO phase left by the random writes
        applyReset();
        dcBypassTest();
        cicDecimateTest();
        rotationTest();
        $display("Tests: %0d run, %0d with errors; checks: %0d run, %0d mismatches",
                 testCount, testsWithErrors, checkCount, mismatchCount);
        if (mismatchCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* logic/ddc.sv */
`timescale 1ns/1ps

module ddc #(
    parameter int lutDepthLog2 = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            syncIn,
    input  ddcPkg::sampleT  iIn,
    input  ddcPkg::sampleT  qIn,
    input  logic            wr0,
    input  logic            wr1,
    input  logic            wr2,
    input  logic            wr3,
    input  regPkg::busAddrT addr,
    input  regPkg::busDataT din,
    output regPkg::busDataT dout,
    input  ddcPkg::freqT    freqOffset,
    input  logic            offsetEn,
    input  logic [20:0]     agcGain,
    output logic            syncOut,
    output ddcPkg::sampleT  iOut,
    output ddcPkg::sampleT  qOut
);

    cpuBus bus ();

    logic           ddcCs, cicCs;
    logic           bypassCic, bypassHb;
    ddcPkg::freqT   centerFreq, offsetHeld, loFreq;
    ddcPkg::sampleT cosLo, sinLo;
    logic           mixSync, hbSync, hbSelSync, cicSync, agcSync;
    ddcPkg::sampleT mixI, mixQ, hbI, hbQ, hbSelI, hbSelQ;
    ddcPkg::cicAccT cicI, cicQ, agcI, agcQ;

    assign bus.addr     = addr;
    assign bus.din      = din;
    assign bus.wrStrobe = {wr3, wr2, wr1, wr0};

    assign ddcCs = addr[11:8] == regPkg::ddcSpaceBase;
    assign cicCs = addr[11:8] == regPkg::cicSpaceBase;

    always_comb begin
        if (ddcCs) begin
            dout = bus.rdData[regPkg::ddcSlot];
        end else if (cicCs) begin
            dout = bus.rdData[regPkg::cicSlot];
        end else begin
            dout = '0;
        end
    end

    ddcRegs regs (.clk, .reset, .bus, .cs(ddcCs), .centerFreq, .bypassCic, .bypassHb);

    // New offset reaches the LO on the same edge it is latched
    always_ff @(posedge clk) begin
        if (reset) begin
            offsetHeld <= '0;
            loFreq     <= '0;
        end else begin
            if (offsetEn) begin
                offsetHeld <= freqOffset;
            end
            loFreq <= centerFreq + (offsetEn ? freqOffset : offsetHeld);
        end
    end

    nco #(.lutDepthLog2(lutDepthLog2)) lo (
        .clk, .reset, .freq(loFreq), .cosOut(cosLo), .sinOut(sinLo)
    );

    complexMixer mixer (
        .clk, .reset, .sync(syncIn),
        .aI(iIn), .aQ(qIn), .bI(cosLo), .bQ(sinLo),
        .syncOut(mixSync), .pI(mixI), .pQ(mixQ)
    );

    halfbandDecimate hb (
        .clk, .reset, .sync(mixSync),
        .iIn(mixI), .qIn(mixQ),
        .syncOut(hbSync), .iOut(hbI), .qOut(hbQ)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            hbSelSync <= 1'b0;
            agcSync   <= 1'b0;
            syncOut   <= 1'b0;
        end else begin
            hbSelSync <= bypassHb ? mixSync : hbSync;
            agcSync   <= bypassCic ? hbSelSync : cicSync;
            // Gain output lands one cycle after its enable
            syncOut   <= agcSync;
        end
    end

    always_ff @(posedge clk) begin
        hbSelI <= bypassHb ? mixI : hbI;
        hbSelQ <= bypassHb ? mixQ : hbQ;
        agcI   <= bypassCic ? {hbSelI, {ddcPkg::padBits{1'b0}}} : cicI;
        agcQ   <= bypassCic ? {hbSelQ, {ddcPkg::padBits{1'b0}}} : cicQ;
    end

    cicDecimator cic (
        .clk, .reset, .sync(hbSelSync), .bus, .cs(cicCs),
        .inI(hbSelI), .inQ(hbSelQ),
        .syncOut(cicSync), .outI(cicI), .outQ(cicQ)
    );

    variableGain gainI (
        .clk, .enable(agcSync),
        .exponent(agcGain[20:16]), .mantissa(agcGain[15:0]),
        .din(agcI), .dout(iOut)
    );

    variableGain gainQ (
        .clk, .enable(agcSync),
        .exponent(agcGain[20:16]), .mantissa(agcGain[15:0]),
        .din(agcQ), .dout(qOut)
    );

endmodule

/* logic/variableGain.sv */
`timescale 1ns/1ps

module variableGain (
    input  logic             clk,
    input  logic             enable,
    input  ddcPkg::gainExpT  exponent,
    input  ddcPkg::gainManT  mantissa,
    input  ddcPkg::cicAccT   din,
    output ddcPkg::sampleT   dout
);

    // Mantissa has 15 fraction bits, data carries the CIC pad below the sample
    localparam int manFracBits = 15;
    localparam int gainShift   = manFracBits + ddcPkg::padBits;

    logic signed [79:0] shifted;
    logic signed [96:0] scaled;

    assign shifted = 80'(din) <<< exponent;
    assign scaled  = 97'(shifted) * 97'($signed({1'b0, mantissa}));

    always_ff @(posedge clk) begin
        if (enable) begin
            dout <= ddcPkg::satSample(ddcPkg::wideT'(scaled >>> gainShift));
        end
    end

endmodule

/* cic/cicDecimator.sv */
`timescale 1ns/1ps

module cicDecimator (
    input  logic            clk,
    input  logic            reset,
    input  logic            sync,
    cpuBus.target           bus,
    input  logic            cs,
    input  ddcPkg::sampleT  inI,
    input  ddcPkg::sampleT  inQ,
    output logic            syncOut,
    output ddcPkg::cicAccT  outI,
    output ddcPkg::cicAccT  outQ
);

    localparam int lastStage = ddcPkg::cicStages - 1;

    regPkg::busDataT   rateWord;
    regPkg::busOffsetT offset;
    logic [4:0]        rate;
    logic [4:0]        sampleCount;
    logic              lastSample;
    logic              dump;

    ddcPkg::sampleT chanIn [2];
    ddcPkg::cicAccT integ [2][ddcPkg::cicStages];
    ddcPkg::cicAccT combDly [2][ddcPkg::cicStages];
    ddcPkg::cicAccT combVal [2][ddcPkg::cicStages];
    ddcPkg::cicAccT chanOut [2];

    assign chanIn[0] = inI;
    assign chanIn[1] = inQ;
    assign outI      = chanOut[0];
    assign outQ      = chanOut[1];
    assign offset    = bus.addr[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            rateWord <= 32'd4;
        end else if (cs && offset == regPkg::cicRateAddr) begin
            rateWord <= regPkg::byteMerge(rateWord, bus.din, bus.wrStrobe);
        end
    end

    assign bus.rdData[regPkg::cicSlot] = (offset == regPkg::cicRateAddr) ? rateWord : '0;

    // Out-of-range words are pinned to the nearest legal rate
    always_comb begin
        if (rateWord < 32'd2) begin
            rate = 5'd2;
        end else if (rateWord > 32'd16) begin
            rate = 5'd16;
        end else begin
            rate = rateWord[4:0];
        end
    end

    assign lastSample = sampleCount >= rate - 5'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCount <= '0;
            dump        <= 1'b0;
            syncOut     <= 1'b0;
        end else begin
            if (sync) begin
                sampleCount <= lastSample ? 5'd0 : sampleCount + 5'd1;
            end
            dump    <= sync && lastSample;
            syncOut <= dump;
        end
    end

    // Comb chain runs combinationally, registered at the decimated rate
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            combVal[c][0] = integ[c][lastStage] - combDly[c][0];
            for (int s = 1; s < ddcPkg::cicStages; s++) begin
                combVal[c][s] = combVal[c][s-1] - combDly[c][s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < 2; c++) begin
                for (int s = 0; s < ddcPkg::cicStages; s++) begin
                    integ[c][s]   <= '0;
                    combDly[c][s] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (sync) begin
                    integ[c][0] <= integ[c][0] + ddcPkg::cicAccT'(chanIn[c]);
                    for (int s = 1; s < ddcPkg::cicStages; s++) begin
                        integ[c][s] <= integ[c][s] + integ[c][s-1];
                    end
                end
                if (dump) begin
                    combDly[c][0] <= integ[c][lastStage];
                    for (int s = 1; s < ddcPkg::cicStages; s++) begin
                        combDly[c][s] <= combVal[c][s-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (dump) begin
                chanOut[c] <= combVal[c][lastStage];
            end
        end
    end

    // Samples only arrive with a legal rate word programmed
    assert property (@(posedge clk) disable iff (reset)
        sync |-> rateWord >= 32'd2 && rateWord <= 32'd16);

endmodule

/* logic/halfbandDecimate.sv */
`timescale 1ns/1ps

module halfbandDecimate (
    input  logic            clk,
    input  logic            reset,
    input  logic            sync,
    input  ddcPkg::sampleT  iIn,
    input  ddcPkg::sampleT  qIn,
    output logic            syncOut,
    output ddcPkg::sampleT  iOut,
    output ddcPkg::sampleT  qOut
);

    localparam int numTaps   = 7;
    localparam int coefShift = 5;

    ddcPkg::sampleT     chanIn [2];
    ddcPkg::sampleT     line [2][numTaps];
    logic signed [18:0] outerSum [2];
    logic signed [18:0] innerSum [2];
    ddcPkg::sampleT     center [2];
    logic signed [23:0] weighted [2];
    ddcPkg::sampleT     chanOut [2];
    logic               oddPhase;
    logic [2:0]         validPipe;

    assign chanIn[0] = iIn;
    assign chanIn[1] = qIn;
    assign iOut      = chanOut[0];
    assign qOut      = chanOut[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            oddPhase  <= 1'b0;
            validPipe <= '0;
            syncOut   <= 1'b0;
        end else begin
            if (sync) begin
                oddPhase <= ~oddPhase;
            end
            validPipe <= {validPipe[1:0], sync & oddPhase};
            syncOut   <= validPipe[2];
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (sync) begin
                line[c][0] <= chanIn[c];
                for (int k = 1; k < numTaps; k++) begin
                    line[c][k] <= line[c][k-1];
                end
            end
            // Symmetric taps share one adder per pair
            outerSum[c] <= 19'(line[c][0]) + 19'(line[c][6]);
            innerSum[c] <= 19'(line[c][2]) + 19'(line[c][4]);
            center[c]   <= line[c][3];
            // -1, 9, 16 as shifts and adds
            weighted[c] <= (24'(innerSum[c]) <<< 3) + 24'(innerSum[c])
                         + (24'(center[c]) <<< 4) - 24'(outerSum[c]);
            if (validPipe[2]) begin
                chanOut[c] <= ddcPkg::satSample(ddcPkg::wideT'(
                    (weighted[c] + 24'sd16) >>> coefShift));
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) syncOut |=> !syncOut);

endmodule

/* logic/complexMixer.sv */
`timescale 1ns/1ps

module complexMixer (
    input  logic            clk,
    input  logic            reset,
    input  logic            sync,
    input  ddcPkg::sampleT  aI,
    input  ddcPkg::sampleT  aQ,
    input  ddcPkg::sampleT  bI,
    input  ddcPkg::sampleT  bQ,
    output logic            syncOut,
    output ddcPkg::sampleT  pI,
    output ddcPkg::sampleT  pQ
);

    localparam logic signed [36:0] roundHalf = 37'sd1 <<< (ddcPkg::mixFracBits - 1);

    logic signed [35:0] prodII, prodQQ, prodIQ, prodQI;
    logic signed [36:0] sumRe, sumIm;
    logic [1:0]         syncPipe;

    always_ff @(posedge clk) begin
        if (reset) begin
            syncPipe <= '0;
            syncOut  <= 1'b0;
        end else begin
            syncPipe <= {syncPipe[0], sync};
            syncOut  <= syncPipe[1];
        end
    end

    always_ff @(posedge clk) begin
        prodII <= aI * bI;
        prodQQ <= aQ * bQ;
        prodIQ <= aI * bQ;
        prodQI <= aQ * bI;
        // Rounding constant folded into the adder stage
        sumRe  <= 37'(prodII) - 37'(prodQQ) + roundHalf;
        sumIm  <= 37'(prodIQ) + 37'(prodQI) + roundHalf;
        pI     <= ddcPkg::satSample(ddcPkg::wideT'(sumRe >>> ddcPkg::mixFracBits));
        pQ     <= ddcPkg::satSample(ddcPkg::wideT'(sumIm >>> ddcPkg::mixFracBits));
    end

endmodule

/* logic/nco.sv */
`timescale 1ns/1ps

module nco #(
    parameter int lutDepthLog2 = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  ddcPkg::freqT    freq,
    output ddcPkg::sampleT  cosOut,
    output ddcPkg::sampleT  sinOut
);

    localparam int  lutSize = 1 << lutDepthLog2;
    localparam real pi      = 3.14159265358979;

    typedef logic [lutDepthLog2-1:0] lutIdxT;

    ddcPkg::freqT   phase;
    ddcPkg::sampleT quarterLut [lutSize];
    logic [1:0]     quadrant;
    lutIdxT         idx;
    lutIdxT         revIdx;
    ddcPkg::sampleT fwdMag;
    ddcPkg::sampleT revMag;
    ddcPkg::sampleT sinNext;
    ddcPkg::sampleT cosNext;

    // First quarter of a sine wave, entry 0 is zero
    for (genvar k = 0; k < lutSize; k++) begin : gLut
        assign quarterLut[k] =
            ddcPkg::sampleT'(int'($sin(pi * k / (2.0 * lutSize)) * ddcPkg::sampleMax));
    end

    assign quadrant = phase[31:30];
    assign idx      = phase[29 -: lutDepthLog2];
    assign revIdx   = -idx;
    assign fwdMag   = quarterLut[idx];
    // Mirrored index falls off the table at idx 0, where the value is full scale
    assign revMag   = (idx == '0) ? ddcPkg::sampleMax : quarterLut[revIdx];

    always_comb begin
        sinNext = quadrant[0] ? revMag : fwdMag;
        cosNext = quadrant[0] ? fwdMag : revMag;
        if (quadrant[1]) begin
            sinNext = -sinNext;
        end
        if (quadrant[1] ^ quadrant[0]) begin
            cosNext = -cosNext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase  <= '0;
            cosOut <= '0;
            sinOut <= '0;
        end else begin
            phase  <= phase + freq;
            cosOut <= cosNext;
            sinOut <= sinNext;
        end
    end

endmodule

/* logic/ddcRegs.sv */
`timescale 1ns/1ps

module ddcRegs (
    input  logic          clk,
    input  logic          reset,
    cpuBus.target         bus,
    input  logic          cs,
    output ddcPkg::freqT  centerFreq,
    output logic          bypassCic,
    output logic          bypassHb
);

    regPkg::busDataT   controlWord;
    regPkg::busOffsetT offset;

    assign offset = bus.addr[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            centerFreq  <= '0;
            controlWord <= '0;
        end else if (cs) begin
            if (offset == regPkg::centerFreqAddr) begin
                centerFreq <= regPkg::byteMerge(centerFreq, bus.din, bus.wrStrobe);
            end
            if (offset == regPkg::controlAddr) begin
                controlWord <= regPkg::byteMerge(controlWord, bus.din, bus.wrStrobe);
            end
        end
    end

    assign bypassCic = controlWord[regPkg::bypassCicBit];
    assign bypassHb  = controlWord[regPkg::bypassHbBit];

    always_comb begin
        case (offset)
            regPkg::centerFreqAddr: bus.rdData[regPkg::ddcSlot] = centerFreq;
            regPkg::controlAddr:    bus.rdData[regPkg::ddcSlot] = controlWord;
            default:                bus.rdData[regPkg::ddcSlot] = '0;
        endcase
    end

    // A register only changes after a selected strobe on the previous edge
    assert property (@(posedge clk) disable iff (reset)
        ($past(centerFreq) != centerFreq || $past(controlWord) != controlWord)
            |-> $past(cs && bus.wrStrobe != '0));

endmodule

/* common/cpuBus.sv */
`timescale 1ns/1ps

interface cpuBus;

    regPkg::busAddrT   addr;
    regPkg::busDataT   din;
    regPkg::busStrobeT wrStrobe;

    // One read word per target, selected by space in the top level
    regPkg::busDataT   rdData [regPkg::numTargets];

    modport controller (
        output addr,
        output din,
        output wrStrobe,
        input  rdData
    );

    modport target (
        input  addr,
        input  din,
        input  wrStrobe,
        output rdData
    );

endinterface

/* common/regPkg.sv */
package regPkg;

    typedef logic [11:0] busAddrT;
    typedef logic [31:0] busDataT;
    typedef logic [3:0]  busStrobeT;
    typedef logic [3:0]  busSpaceT;
    typedef logic [7:0]  busOffsetT;

    // Space is addr[11:8], word offset is addr[7:0]
    localparam busSpaceT ddcSpaceBase = 4'h0;
    localparam busSpaceT cicSpaceBase = 4'h1;

    localparam busOffsetT centerFreqAddr = 8'h00;
    localparam busOffsetT controlAddr    = 8'h01;
    localparam busOffsetT cicRateAddr    = 8'h00;

    localparam int bypassCicBit = 0;
    localparam int bypassHbBit  = 1;

    // Read-data slot of each bus target
    localparam int numTargets = 2;
    localparam int ddcSlot    = 0;
    localparam int cicSlot    = 1;

    function automatic busDataT byteMerge(busDataT old, busDataT wrData, busStrobeT strobe);
        busDataT merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = wrData[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* common/ddcPkg.sv */
package ddcPkg;

    typedef logic signed [17:0]  sampleT;
    typedef logic signed [47:0]  cicAccT;
    typedef logic [31:0]         freqT;
    typedef logic [4:0]          gainExpT;
    typedef logic [15:0]         gainManT;

    // Scratch width for intermediate products before saturation
    typedef logic signed [127:0] wideT;

    localparam sampleT sampleMax = 18'sd131071;
    localparam sampleT sampleMin = -sampleMax - 18'sd1;

    localparam int cicStages   = 3;
    localparam int padBits     = $bits(cicAccT) - $bits(sampleT);
    localparam int mixFracBits = $bits(sampleT) - 1;

    function automatic sampleT satSample(wideT value);
        if (value > wideT'(sampleMax)) begin
            return sampleMax;
        end
        if (value < wideT'(sampleMin)) begin
            return sampleMin;
        end
        return sampleT'(value);
    endfunction

endpackage
